/* list.f */
logic/gmacPkg.sv
logic/frameL2.sv
logic/frameL3.sv
logic/frameL4.sv
logic/customGmacRx.sv
sim/gmacRxChecks.sv
sim/gmacRxTb.sv

/* logic/customGmacRx.sv */
`timescale 1ns/1ps

module customGmacRx
#(
    parameter int errCountWidth = 32
)
(
    input  logic                     RXC,
    input  logic                     rstN,
    input  logic                     valIn,
    input  logic                     sofIn,
    input  logic                     eofIn,
    input  logic                     errIn,
    input  logic [7:0]               dataIn,
    input  logic [47:0]              innerMac,
    input  logic [31:0]              ipd,
    input  logic [15:0]              portD,
    output logic                     valOut,
    output logic                     sofOut,
    output logic                     eofOut,
    output logic                     errOut,
    output logic [7:0]               dataOut,
    output logic [47:0]              remoteMacOut,
    output logic [31:0]              remoteIpOut,
    output logic [15:0]              remotePortOut,
    output logic                     arpSeen,
    output logic [errCountWidth-1:0] errFrameCount
);

    // L2 to L3 stream
    logic        valL2;
    logic        sofL2;
    logic        eofL2;
    logic        errL2;
    logic [7:0]  dataL2;
    logic [47:0] remoteMacL2;

    // L3 to L4 stream
    logic        valL3;
    logic        sofL3;
    logic        eofL3;
    logic        errL3;
    logic [7:0]  dataL3;
    logic [47:0] remoteMacL3;
    logic [31:0] remoteIpL3;

    frameL2 #(
        .errCountWidth (errCountWidth)
    ) frameL2Inst (
        .RXC           (RXC),
        .rstN          (rstN),
        .valIn         (valIn),
        .sofIn         (sofIn),
        .eofIn         (eofIn),
        .errIn         (errIn),
        .dataIn        (dataIn),
        .innerMac      (innerMac),
        .valOut        (valL2),
        .sofOut        (sofL2),
        .eofOut        (eofL2),
        .errOut        (errL2),
        .dataOut       (dataL2),
        .remoteMacOut  (remoteMacL2),
        .arpSeen       (arpSeen),
        .errFrameCount (errFrameCount)
    );

    frameL3 frameL3Inst (
        .RXC          (RXC),
        .rstN         (rstN),
        .valIn        (valL2),
        .sofIn        (sofL2),
        .eofIn        (eofL2),
        .errIn        (errL2),
        .dataIn       (dataL2),
        .remoteMacIn  (remoteMacL2),
        .ipd          (ipd),
        .valOut       (valL3),
        .sofOut       (sofL3),
        .eofOut       (eofL3),
        .errOut       (errL3),
        .dataOut      (dataL3),
        .remoteMacOut (remoteMacL3),
        .remoteIpOut  (remoteIpL3)
    );

    frameL4 frameL4Inst (
        .RXC           (RXC),
        .rstN          (rstN),
        .valIn         (valL3),
        .sofIn         (sofL3),
        .eofIn         (eofL3),
        .errIn         (errL3),
        .dataIn        (dataL3),
        .remoteMacIn   (remoteMacL3),
        .remoteIpIn    (remoteIpL3),
        .portD         (portD),
        .valOut        (valOut),
        .sofOut        (sofOut),
        .eofOut        (eofOut),
        .errOut        (errOut),
        .dataOut       (dataOut),
        .remoteMacOut  (remoteMacOut),
        .remoteIpOut   (remoteIpOut),
        .remotePortOut (remotePortOut)
    );

endmodule

/* logic/frameL2.sv */
`timescale 1ns/1ps

module frameL2
    import gmacPkg::*;
#(
    parameter int errCountWidth = 32
)
(
    input  logic                     RXC,
    input  logic                     rstN,
    input  logic                     valIn,
    input  logic                     sofIn,
    input  logic                     eofIn,
    input  logic                     errIn,
    input  logic [7:0]               dataIn,
    input  logic [47:0]              innerMac,
    output logic                     valOut,
    output logic                     sofOut,
    output logic                     eofOut,
    output logic                     errOut,
    output logic [7:0]               dataOut,
    output logic [47:0]              remoteMacOut,
    output logic                     arpSeen,
    output logic [errCountWidth-1:0] errFrameCount
);

    localparam logic [3:0] lastHdrIdx = 4'(macHeaderLen - 1);

    l2StateT     state;
    logic [3:0]  byteCnt;
    logic [3:0]  idx;
    logic        inHeader;
    logic        firstPending;
    logic        errAny;
    logic        errNow;
    logic        arpPending;
    logic [47:0] dstMac;
    logic [47:0] srcMac;
    logic [7:0]  typeHi;
    logic [15:0] etherType;
    etherKindT   kind;
    logic        macOk;

    // Position of the current byte; SoF always restarts at zero
    assign idx = sofIn ? 4'd0 : byteCnt;
    assign errNow = errIn || (errAny && !sofIn);
    assign macOk = (dstMac == innerMac) || (dstMac == broadcastMac);
    // Bytes before the first SoF are ignored
    assign inHeader = valIn && (sofIn || (state == l2Header && byteCnt != 4'd0));
    assign etherType = {typeHi, dataIn};

    always_comb
    begin
        if (etherType == etherTypeIpv4)
            kind = ethIpv4;
        else if (etherType == etherTypeArp)
            kind = ethArp;
        else
            kind = ethOther;
    end

    always_ff @(posedge RXC)
    begin
        if (!rstN)
        begin
            state         <= l2Header;
            byteCnt       <= '0;
            firstPending  <= 1'b0;
            errAny        <= 1'b0;
            arpPending    <= 1'b0;
            valOut        <= 1'b0;
            sofOut        <= 1'b0;
            eofOut        <= 1'b0;
            errOut        <= 1'b0;
            arpSeen       <= 1'b0;
            remoteMacOut  <= '0;
            errFrameCount <= '0;
        end
        else
        begin
            valOut  <= 1'b0;
            sofOut  <= 1'b0;
            eofOut  <= 1'b0;
            errOut  <= 1'b0;
            arpSeen <= 1'b0;
            if (valIn)
                errAny <= errNow;
            // Errored frames count whatever their address
            if (valIn && eofIn && errNow)
                errFrameCount <= errFrameCount + 1'b1;
            if (inHeader)
            begin
                byteCnt <= idx + 4'd1;
                state   <= l2Header;
                if (idx == lastHdrIdx)
                begin
                    firstPending <= 1'b1;
                    arpPending   <= macOk && (kind == ethArp);
                    state        <= (macOk && kind == ethIpv4) ? l2Payload : l2Drop;
                end
            end
            else if (valIn)
            begin
                if (state == l2Payload)
                begin
                    valOut       <= 1'b1;
                    sofOut       <= firstPending;
                    eofOut       <= eofIn;
                    errOut       <= eofIn && errNow;
                    firstPending <= 1'b0;
                    if (firstPending)
                        remoteMacOut <= srcMac;
                end
                if (eofIn)
                begin
                    arpSeen    <= arpPending;
                    arpPending <= 1'b0;
                end
            end
            if (valIn && eofIn)
            begin
                byteCnt <= '0;
                state   <= l2Header;
            end
        end
    end

    // Header fields and payload byte
    always_ff @(posedge RXC)
    begin
        if (valIn)
            dataOut <= dataIn;
        if (inHeader)
        begin
            if (idx < 4'd6)
                dstMac <= {dstMac[39:0], dataIn};
            else if (idx < 4'd12)
                srcMac <= {srcMac[39:0], dataIn};
            else if (idx == 4'd12)
                typeHi <= dataIn;
        end
    end

    // Marks only ride on a valid byte
    assert property (@(posedge RXC) disable iff (!rstN)
        (sofIn || eofIn) |-> valIn);

    assert property (@(posedge RXC) disable iff (!rstN)
        (state == l2Drop) |-> !valOut);

endmodule

/* logic/frameL3.sv */
`timescale 1ns/1ps

module frameL3
    import gmacPkg::*;
(
    input  logic        RXC,
    input  logic        rstN,
    input  logic        valIn,
    input  logic        sofIn,
    input  logic        eofIn,
    input  logic        errIn,
    input  logic [7:0]  dataIn,
    input  logic [47:0] remoteMacIn,
    input  logic [31:0] ipd,
    output logic        valOut,
    output logic        sofOut,
    output logic        eofOut,
    output logic        errOut,
    output logic [7:0]  dataOut,
    output logic [47:0] remoteMacOut,
    output logic [31:0] remoteIpOut
);

    localparam logic [5:0] dstIpLastIdx = 6'd19;

    l3StateT     state;
    logic [5:0]  byteCnt;
    logic [5:0]  idx;
    logic [5:0]  hdrLastIdx;
    logic        inHeader;
    logic        firstPending;
    logic        errAny;
    logic        errNow;
    logic [3:0]  ihl;
    ipProtoT     proto;
    logic [31:0] srcIp;
    logic [31:0] dstIp;
    logic [31:0] dstIpNow;
    logic        headerOk;

    assign idx = sofIn ? 6'd0 : byteCnt;
    assign errNow = errIn || (errAny && !sofIn);
    assign inHeader = valIn && (sofIn || (state == l3Header && byteCnt != 6'd0));
    // IHL counts 32-bit words, options included
    assign hdrLastIdx = {ihl, 2'b00} - 6'd1;
    // Without options the last destination byte is also the last header byte
    assign dstIpNow = (idx == dstIpLastIdx) ? {dstIp[23:0], dataIn} : dstIp;
    assign headerOk = (proto == protoUdp) && (dstIpNow == ipd);

    always_ff @(posedge RXC)
    begin
        if (!rstN)
        begin
            state        <= l3Header;
            byteCnt      <= '0;
            firstPending <= 1'b0;
            errAny       <= 1'b0;
            valOut       <= 1'b0;
            sofOut       <= 1'b0;
            eofOut       <= 1'b0;
            errOut       <= 1'b0;
            remoteMacOut <= '0;
            remoteIpOut  <= '0;
        end
        else
        begin
            valOut <= 1'b0;
            sofOut <= 1'b0;
            eofOut <= 1'b0;
            errOut <= 1'b0;
            if (valIn)
                errAny <= errNow;
            if (inHeader)
            begin
                byteCnt <= idx + 6'd1;
                state   <= l3Header;
                if (idx == 6'd0)
                begin
                    // Version 4 and a minimal header length
                    if (dataIn[7:4] != 4'd4 || dataIn[3:0] < 4'd5)
                        state <= l3Drop;
                end
                else if (idx == hdrLastIdx)
                begin
                    firstPending <= 1'b1;
                    state        <= headerOk ? l3Payload : l3Drop;
                end
            end
            else if (valIn && state == l3Payload)
            begin
                valOut       <= 1'b1;
                sofOut       <= firstPending;
                eofOut       <= eofIn;
                errOut       <= eofIn && errNow;
                firstPending <= 1'b0;
                if (firstPending)
                begin
                    remoteMacOut <= remoteMacIn;
                    remoteIpOut  <= srcIp;
                end
            end
            if (valIn && eofIn)
            begin
                byteCnt <= '0;
                state   <= l3Header;
            end
        end
    end

    always_ff @(posedge RXC)
    begin
        if (valIn)
            dataOut <= dataIn;
        if (inHeader)
        begin
            if (idx == 6'd0)
                ihl <= dataIn[3:0];
            if (idx == 6'd9)
                proto <= ipProtoT'(dataIn);
            if (idx >= 6'd12 && idx <= 6'd15)
                srcIp <= {srcIp[23:0], dataIn};
            if (idx >= 6'd16 && idx <= dstIpLastIdx)
                dstIp <= {dstIp[23:0], dataIn};
        end
    end

    // Every passed frame is closed before the next one opens
    assert property (@(posedge RXC) disable iff (!rstN)
        (valOut && sofOut && !eofOut) |=> !(valOut && sofOut) until_with (valOut && eofOut));

endmodule

/* logic/frameL4.sv */
`timescale 1ns/1ps

module frameL4
    import gmacPkg::*;
(
    input  logic        RXC,
    input  logic        rstN,
    input  logic        valIn,
    input  logic        sofIn,
    input  logic        eofIn,
    input  logic        errIn,
    input  logic [7:0]  dataIn,
    input  logic [47:0] remoteMacIn,
    input  logic [31:0] remoteIpIn,
    input  logic [15:0] portD,
    output logic        valOut,
    output logic        sofOut,
    output logic        eofOut,
    output logic        errOut,
    output logic [7:0]  dataOut,
    output logic [47:0] remoteMacOut,
    output logic [31:0] remoteIpOut,
    output logic [15:0] remotePortOut
);

    localparam logic [2:0] lastHdrIdx = 3'(udpHeaderLen - 1);

    l4StateT     state;
    logic [2:0]  byteCnt;
    logic [2:0]  idx;
    logic        inHeader;
    logic        firstPending;
    logic        errAny;
    logic        errNow;
    logic [15:0] srcPort;
    logic [7:0]  dstPortHi;
    logic        portOk;

    assign idx = sofIn ? 3'd0 : byteCnt;
    assign errNow = errIn || (errAny && !sofIn);
    assign inHeader = valIn && (sofIn || (state == l4Header && byteCnt != 3'd0));

    always_ff @(posedge RXC)
    begin
        if (!rstN)
        begin
            state         <= l4Header;
            byteCnt       <= '0;
            firstPending  <= 1'b0;
            errAny        <= 1'b0;
            valOut        <= 1'b0;
            sofOut        <= 1'b0;
            eofOut        <= 1'b0;
            errOut        <= 1'b0;
            remoteMacOut  <= '0;
            remoteIpOut   <= '0;
            remotePortOut <= '0;
        end
        else
        begin
            valOut <= 1'b0;
            sofOut <= 1'b0;
            eofOut <= 1'b0;
            errOut <= 1'b0;
            if (valIn)
                errAny <= errNow;
            if (inHeader)
            begin
                byteCnt <= idx + 3'd1;
                state   <= l4Header;
                if (idx == lastHdrIdx)
                begin
                    firstPending <= 1'b1;
                    state        <= portOk ? l4Payload : l4Drop;
                end
            end
            else if (valIn && state == l4Payload)
            begin
                valOut       <= 1'b1;
                sofOut       <= firstPending;
                eofOut       <= eofIn;
                errOut       <= eofIn && errNow;
                firstPending <= 1'b0;
                // Remote triple switches over with the first payload byte
                if (firstPending)
                begin
                    remoteMacOut  <= remoteMacIn;
                    remoteIpOut   <= remoteIpIn;
                    remotePortOut <= srcPort;
                end
            end
            if (valIn && eofIn)
            begin
                byteCnt <= '0;
                state   <= l4Header;
            end
        end
    end

    always_ff @(posedge RXC)
    begin
        if (valIn)
            dataOut <= dataIn;
        if (inHeader)
        begin
            if (idx < 3'd2)
                srcPort <= {srcPort[7:0], dataIn};
            if (idx == 3'd2)
                dstPortHi <= dataIn;
            if (idx == 3'd3)
                portOk <= ({dstPortHi, dataIn} == portD);
        end
    end

    assert property (@(posedge RXC) disable iff (!rstN)
        !$stable({remoteMacOut, remoteIpOut, remotePortOut}) |-> sofOut);

endmodule

/* logic/gmacPkg.sv */
package gmacPkg;

    // Frame class after EtherType decode
    typedef enum logic [1:0]
    {
        ethIpv4,
        ethArp,
        ethOther
    } etherKindT;

    typedef enum logic [1:0]
    {
        l2Header,
        l2Payload,
        l2Drop
    } l2StateT;

    typedef enum logic [1:0]
    {
        l3Header,
        l3Payload,
        l3Drop
    } l3StateT;

    typedef enum logic [1:0]
    {
        l4Header,
        l4Payload,
        l4Drop
    } l4StateT;

    // IP protocol field values
    typedef enum logic [7:0]
    {
        protoUdp   = 8'd17,
        protoOther = 8'd255
    } ipProtoT;

    localparam logic [15:0] etherTypeIpv4 = 16'h0800;
    localparam logic [15:0] etherTypeArp  = 16'h0806;

    localparam int unsigned macHeaderLen = 14;
    localparam int unsigned udpHeaderLen = 8;

    localparam logic [47:0] broadcastMac = 48'hFFFF_FFFF_FFFF;

endpackage

/* sim/gmacRxChecks.sv */
`timescale 1ns/1ps

module gmacRxChecks
#(
    parameter int errCountWidth = 32
)
(
    input logic                     RXC,
    input logic                     rstN,
    // DUT outputs
    input logic                     valOut,
    input logic                     sofOut,
    input logic                     eofOut,
    input logic                     errOut,
    input logic [7:0]               dataOut,
    input logic [47:0]              remoteMacOut,
    input logic [31:0]              remoteIpOut,
    input logic [15:0]              remotePortOut,
    input logic                     arpSeen,
    input logic [errCountWidth-1:0] errFrameCount,
    // Expectation for the byte driven in this cycle
    input logic                     expVal,
    input logic                     expSof,
    input logic                     expEof,
    input logic                     expErr,
    input logic [7:0]               expData,
    input logic [47:0]              expMac,
    input logic [31:0]              expIp,
    input logic [15:0]              expPort,
    input logic                     expErrFrame,
    input logic                     expArp
);

    int errCount = 0;
    int bytesChecked = 0;
    int framesChecked = 0;

    // Three register stages, one per parser stage
    logic [107:0]             expLine [0:2];
    logic [errCountWidth-1:0] expCount;
    logic                     arpDue;
    logic                     dVal;
    logic                     dSof;
    logic                     dEof;
    logic                     dErr;
    logic [7:0]               dData;
    logic [47:0]              dMac;
    logic [31:0]              dIp;
    logic [15:0]              dPort;

    assign {dVal, dSof, dEof, dErr, dData, dMac, dIp, dPort} = expLine[2];

    task automatic noteMismatch(input string name, input logic [63:0] expV,
                                input logic [63:0] actV);
        errCount++;
        $display("ERR %s expected 0x%0h actual 0x%0h at %0t", name, expV, actV, $time);
    endtask

    always_ff @(posedge RXC)
    begin
        if (!rstN)
        begin
            expLine[0] <= '0;
            expLine[1] <= '0;
            expLine[2] <= '0;
            expCount   <= '0;
            arpDue     <= 1'b0;
        end
        else
        begin
            expLine[0] <= {expVal, expSof, expEof, expErr, expData, expMac, expIp, expPort};
            expLine[1] <= expLine[0];
            expLine[2] <= expLine[1];
            if (expErrFrame)
                expCount <= expCount + 1'b1;
            arpDue <= expArp;
            if (valOut)
                bytesChecked <= bytesChecked + 1;
            if (valOut && sofOut)
                framesChecked <= framesChecked + 1;
        end
    end

    assert property (@(posedge RXC) disable iff (!rstN) valOut == dVal)
        else noteMismatch("valOut", $sampled(dVal), $sampled(valOut));

    assert property (@(posedge RXC) disable iff (!rstN) valOut |-> sofOut == dSof)
        else noteMismatch("sofOut", $sampled(dSof), $sampled(sofOut));

    assert property (@(posedge RXC) disable iff (!rstN) valOut |-> eofOut == dEof)
        else noteMismatch("eofOut", $sampled(dEof), $sampled(eofOut));

    assert property (@(posedge RXC) disable iff (!rstN) valOut |-> errOut == dErr)
        else noteMismatch("errOut", $sampled(dErr), $sampled(errOut));

    assert property (@(posedge RXC) disable iff (!rstN) valOut |-> dataOut == dData)
        else noteMismatch("dataOut", $sampled(dData), $sampled(dataOut));

    // Remote triple is checked on the first payload byte
    assert property (@(posedge RXC) disable iff (!rstN)
        (valOut && sofOut) |-> remoteMacOut == dMac)
        else noteMismatch("remoteMacOut", $sampled(dMac), $sampled(remoteMacOut));

    assert property (@(posedge RXC) disable iff (!rstN)
        (valOut && sofOut) |-> remoteIpOut == dIp)
        else noteMismatch("remoteIpOut", $sampled(dIp), $sampled(remoteIpOut));

    assert property (@(posedge RXC) disable iff (!rstN)
        (valOut && sofOut) |-> remotePortOut == dPort)
        else noteMismatch("remotePortOut", $sampled(dPort), $sampled(remotePortOut));

    assert property (@(posedge RXC) disable iff (!rstN) errFrameCount == expCount)
        else noteMismatch("errFrameCount", $sampled(expCount), $sampled(errFrameCount));

    assert property (@(posedge RXC) disable iff (!rstN) arpSeen == arpDue)
        else noteMismatch("arpSeen", $sampled(arpDue), $sampled(arpSeen));

endmodule

/* sim/gmacRxTb.sv */
`timescale 1ns/1ps

module gmacRxTb
    import gmacPkg::*;
();

    localparam int numFrames   = 12;
    localparam int maxPayLen   = 40;
    localparam int resetCycles = 4;
    localparam int drainCycles = 8;
    // Longest frame carries four option bytes
    localparam int maxFrameLen = macHeaderLen + 24 + udpHeaderLen + maxPayLen;
    localparam int watchdogNs  =
        (resetCycles + drainCycles + numFrames * (maxFrameLen + 20)) * 10;

    localparam logic [15:0] ipv4Type = 16'h0800;
    localparam logic [15:0] arpType  = 16'h0806;
    localparam logic [47:0] ourMac   = 48'h02_00_5E_10_20_30;
    localparam logic [31:0] ourIp    = 32'hC0A8_0A02;
    localparam logic [15:0] ourPort  = 16'd5000;
    localparam logic [47:0] peerMac  = 48'h02_11_22_33_44_55;
    localparam logic [31:0] peerIp   = 32'hC0A8_0A63;
    localparam logic [47:0] otherMac = 48'h02_AA_BB_CC_DD_EE;

    logic        RXC = 1'b0;
    logic        rstN;
    logic        valIn;
    logic        sofIn;
    logic        eofIn;
    logic        errIn;
    logic [7:0]  dataIn;
    logic [47:0] innerMac;
    logic [31:0] ipd;
    logic [15:0] portD;
    logic        valOut;
    logic        sofOut;
    logic        eofOut;
    logic        errOut;
    logic [7:0]  dataOut;
    logic [47:0] remoteMacOut;
    logic [31:0] remoteIpOut;
    logic [15:0] remotePortOut;
    logic        arpSeen;
    logic [31:0] errFrameCount;

    logic        expVal;
    logic        expSof;
    logic        expEof;
    logic        expErr;
    logic [7:0]  expData;
    logic [47:0] expMac;
    logic [31:0] expIp;
    logic [15:0] expPort;
    logic        expErrFrame;
    logic        expArp;

    integer      seed;
    logic [7:0]  frameBytes [$];

    always #5 RXC = ~RXC;

    customGmacRx #(
        .errCountWidth (32)
    ) uut (
        .RXC           (RXC),
        .rstN          (rstN),
        .valIn         (valIn),
        .sofIn         (sofIn),
        .eofIn         (eofIn),
        .errIn         (errIn),
        .dataIn        (dataIn),
        .innerMac      (innerMac),
        .ipd           (ipd),
        .portD         (portD),
        .valOut        (valOut),
        .sofOut        (sofOut),
        .eofOut        (eofOut),
        .errOut        (errOut),
        .dataOut       (dataOut),
        .remoteMacOut  (remoteMacOut),
        .remoteIpOut   (remoteIpOut),
        .remotePortOut (remotePortOut),
        .arpSeen       (arpSeen),
        .errFrameCount (errFrameCount)
    );

    gmacRxChecks #(
        .errCountWidth (32)
    ) checks (
        .RXC           (RXC),
        .rstN          (rstN),
        .valOut        (valOut),
        .sofOut        (sofOut),
        .eofOut        (eofOut),
        .errOut        (errOut),
        .dataOut       (dataOut),
        .remoteMacOut  (remoteMacOut),
        .remoteIpOut   (remoteIpOut),
        .remotePortOut (remotePortOut),
        .arpSeen       (arpSeen),
        .errFrameCount (errFrameCount),
        .expVal        (expVal),
        .expSof        (expSof),
        .expEof        (expEof),
        .expErr        (expErr),
        .expData       (expData),
        .expMac        (expMac),
        .expIp         (expIp),
        .expPort       (expPort),
        .expErrFrame   (expErrFrame),
        .expArp        (expArp)
    );

    task automatic clearInputs();
        valIn       = 1'b0;
        sofIn       = 1'b0;
        eofIn       = 1'b0;
        errIn       = 1'b0;
        dataIn      = 8'h00;
        expVal      = 1'b0;
        expSof      = 1'b0;
        expEof      = 1'b0;
        expErr      = 1'b0;
        expErrFrame = 1'b0;
        expArp      = 1'b0;
    endtask

    task automatic idleCycles(input int n);
        repeat (n)
        begin
            @(negedge RXC);
            clearInputs();
        end
    endtask

    // Pushes the low count bytes of value, most significant first
    task automatic appendBytes(input logic [47:0] value, input int count);
        for (int i = count - 1; i >= 0; i--)
            frameBytes.push_back(value[8*i +: 8]);
    endtask

    task automatic sendFrame(input logic [47:0] dstMac, input logic [47:0] srcMac,
                             input logic [15:0] etherType, input logic [3:0] ihl,
                             input logic [7:0] proto, input logic [31:0] dstIp,
                             input logic [31:0] srcIp, input logic [15:0] srcPort,
                             input logic [15:0] dstPort, input int payLen, input int errPos);
        int   firstPay;
        int   last;
        int   gaps;
        int   optLen;
        logic macOk;
        logic pass;
        logic isArp;
        logic hadErr;

        macOk  = (dstMac == ourMac) || (dstMac == broadcastMac);
        isArp  = macOk && etherType == arpType;
        pass   = macOk && etherType == ipv4Type && ihl >= 4'd5 && proto == protoUdp
                 && dstIp == ourIp && dstPort == ourPort;
        hadErr = errPos >= 0;
        optLen = (int'(ihl) - 5) * 4;
        frameBytes.delete();
        appendBytes(dstMac, 6);
        appendBytes(srcMac, 6);
        appendBytes(etherType, 2);
        if (etherType == ipv4Type)
        begin
            appendBytes({4'h4, ihl}, 1);
            appendBytes(8'h00, 1);
            appendBytes(16'(ihl * 4 + udpHeaderLen + payLen), 2);
            // Identification, then DF flag
            appendBytes(32'h1234_4000, 4);
            appendBytes(8'd64, 1);
            appendBytes(proto, 1);
            appendBytes(16'h0000, 2);
            appendBytes(srcIp, 4);
            appendBytes(dstIp, 4);
            // Option bytes are NOPs
            for (int i = 0; i < optLen; i++)
                appendBytes(8'h01, 1);
            appendBytes(srcPort, 2);
            appendBytes(dstPort, 2);
            appendBytes(16'(udpHeaderLen + payLen), 2);
            appendBytes(16'h0000, 2);
        end
        firstPay = frameBytes.size();
        for (int i = 0; i < payLen; i++)
            appendBytes($random(seed), 1);
        last = frameBytes.size() - 1;
        gaps = 0;
        for (int i = 0; i <= last; i++)
        begin
            // A few short idle gaps inside the frame
            if (i > 0 && gaps < 3 && ($random(seed) & 7) == 0)
            begin
                gaps++;
                idleCycles(1 + $unsigned($random(seed)) % 3);
            end
            @(negedge RXC);
            valIn       = 1'b1;
            sofIn       = i == 0;
            eofIn       = i == last;
            errIn       = i == errPos;
            dataIn      = frameBytes[i];
            expVal      = pass && i >= firstPay;
            expSof      = pass && i == firstPay;
            expEof      = pass && i == last;
            expErr      = pass && i == last && hadErr;
            expData     = frameBytes[i];
            expMac      = srcMac;
            expIp       = srcIp;
            expPort     = srcPort;
            expErrFrame = i == last && hadErr;
            expArp      = i == last && isArp;
        end
        idleCycles(2);
    endtask

    initial
    begin
        seed     = 32'h5ca;
        rstN     = 1'b0;
        innerMac = ourMac;
        ipd      = ourIp;
        portD    = ourPort;
        expData  = 8'h00;
        expMac   = '0;
        expIp    = '0;
        expPort  = '0;
        clearInputs();
        repeat (resetCycles) @(negedge RXC);
        rstN = 1'b1;
        idleCycles(2);

        // Good frame, then the four kinds of mismatch
        sendFrame(ourMac, peerMac, ipv4Type, 4'd5, protoUdp, ourIp, peerIp, 16'd1234,
                  ourPort, 32, -1);
        sendFrame(otherMac, peerMac, ipv4Type, 4'd5, protoUdp, ourIp, peerIp, 16'd1234,
                  ourPort, 16, -1);
        sendFrame(ourMac, peerMac, ipv4Type, 4'd5, protoUdp, 32'hC0A8_0A03, peerIp,
                  16'd1234, ourPort, 16, -1);
        sendFrame(ourMac, peerMac, ipv4Type, 4'd5, protoOther, ourIp, peerIp, 16'd1234,
                  ourPort, 16, -1);
        sendFrame(ourMac, peerMac, ipv4Type, 4'd5, protoUdp, ourIp, peerIp, 16'd1234,
                  16'd5001, 16, -1);

        // Broadcast, then IHL 6 from another peer
        sendFrame(broadcastMac, peerMac, ipv4Type, 4'd5, protoUdp, ourIp, peerIp,
                  16'd2222, ourPort, 20, -1);
        sendFrame(ourMac, otherMac, ipv4Type, 4'd6, protoUdp, ourIp, 32'h0A00_0001,
                  16'd4321, ourPort, maxPayLen, -1);

        // Errored frames, one passing and one dropped
        sendFrame(ourMac, peerMac, ipv4Type, 4'd5, protoUdp, ourIp, peerIp, 16'd1234,
                  ourPort, 24, 47);
        sendFrame(otherMac, peerMac, ipv4Type, 4'd5, protoUdp, ourIp, peerIp, 16'd1234,
                  ourPort, 24, 20);

        // ARP for us and for someone else
        sendFrame(ourMac, peerMac, arpType, 4'd0, 8'd0, '0, '0, '0, '0, 28, -1);
        sendFrame(otherMac, peerMac, arpType, 4'd0, 8'd0, '0, '0, '0, '0, 28, -1);

        sendFrame(ourMac, peerMac, ipv4Type, 4'd5, protoUdp, ourIp, peerIp, 16'd1235,
                  ourPort, 12, -1);

        idleCycles(drainCycles);
        $display("Checks done: %0d payload bytes, %0d frames out, %0d errors",
                 checks.bytesChecked, checks.framesChecked, checks.errCount);
        if (checks.errCount == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    initial
    begin
        #(watchdogNs);
        $display("Watchdog expired before the frame sequence finished");
        $display("Simulation failed");
        $finish;
    end

endmodule
